// ==== hdl/lsu_cfg.svh ====
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

`define LSU_XLEN      32
`define LSU_ADDR_W    10
`define LSU_RAM_WORDS 256
`define LSU_SB_DEPTH  4
`define LSU_TAG_W     6
`define LSU_EXC_W     2

// exception codes in writeback
`define LSU_EXC_NONE  2'd0
`define LSU_EXC_LAM   2'd1
`define LSU_EXC_SAM   2'd2

`endif

// ==== hdl/lsu_pkg.sv ====
`include "lsu_cfg.svh"

package lsu_pkg;

    typedef logic [`LSU_XLEN-1:0]   xlen_t;
    typedef logic [`LSU_ADDR_W-1:0] addr_t;
    typedef logic [`LSU_ADDR_W-3:0] waddr_t;
    typedef logic [`LSU_XLEN/8-1:0] bmask_t;
    typedef logic [`LSU_TAG_W-1:0]  tag_t;
    typedef logic [`LSU_EXC_W-1:0]  exc_t;

    typedef enum logic [1:0] {
        SIZE_B = 2'b00,
        SIZE_H = 2'b01,
        SIZE_W = 2'b10
    } mem_size_e;

    typedef struct packed {
        xlen_t     base;
        xlen_t     imm;
        xlen_t     data;
        mem_size_e size;
        logic      uext;
        tag_t      tag;
    } lsu_req_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        xlen_t data;
        exc_t  exccode;
    } lsu_wb_t;

    // data already sits in its byte lanes
    typedef struct packed {
        waddr_t waddr;
        bmask_t mask;
        xlen_t  data;
    } sb_entry_t;

endpackage

// ==== hdl/lsu_addr_gen.sv ====
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_addr_gen (
    input  lsu_pkg::lsu_req_t req_i,
    output lsu_pkg::addr_t    addr_o,
    output lsu_pkg::bmask_t   mask_o,
    output logic              misalign_o
);
    import lsu_pkg::*;

    xlen_t      sum;
    logic [1:0] offset;

    assign sum    = req_i.base + req_i.imm;
    assign addr_o = sum[`LSU_ADDR_W-1:0];
    assign offset = sum[1:0];

    always_comb begin
        case (req_i.size)
            SIZE_W:  misalign_o = |offset;
            SIZE_H:  misalign_o = offset[0];
            default: misalign_o = 1'b0;
        endcase
    end

    // lanes touched by the access
    always_comb begin
        if (req_i.size == SIZE_W) begin
            mask_o = 4'b1111;
        end else if (req_i.size == SIZE_H) begin
            case (offset)
                2'b00:   mask_o = 4'b0011;
                2'b01:   mask_o = 4'b0110;
                2'b10:   mask_o = 4'b1100;
                default: mask_o = 4'b1000;
            endcase
        end else begin
            case (offset)
                2'b00:   mask_o = 4'b0001;
                2'b01:   mask_o = 4'b0010;
                2'b10:   mask_o = 4'b0100;
                default: mask_o = 4'b1000;
            endcase
        end
    end

endmodule

// ==== hdl/store_buffer.sv ====
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module store_buffer (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               enq_i,
    input  lsu_pkg::sb_entry_t enq_entry_i,
    input  logic               commit_i,
    input  lsu_pkg::waddr_t    fwd_waddr_i,
    output lsu_pkg::bmask_t    fwd_mask_o,
    output lsu_pkg::xlen_t     fwd_data_o,
    output logic               ram_we_o,
    output lsu_pkg::sb_entry_t ram_entry_o,
    output logic               full_o
);
    import lsu_pkg::*;

    localparam int PTR_W = $clog2(`LSU_SB_DEPTH);
    localparam int CNT_W = PTR_W + 1;
    localparam int LANES = $bits(bmask_t);

    sb_entry_t        entries [`LSU_SB_DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             deq;

    assign deq         = commit_i & (count != '0);
    assign full_o      = (count == CNT_W'(`LSU_SB_DEPTH));
    assign ram_we_o    = deq;
    assign ram_entry_o = entries[head];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (enq_i) begin
                tail <= tail + 1'b1;
            end
            if (deq) begin
                head <= head + 1'b1;
            end
            case ({enq_i, deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        if (enq_i) begin
            entries[tail] <= enq_entry_i;
        end
    end

    // walk oldest to youngest so the youngest match is left per lane
    always_comb begin
        fwd_mask_o = '0;
        fwd_data_o = '0;
        for (int k = 0; k < `LSU_SB_DEPTH; k++) begin
            if (k < count && entries[PTR_W'(head + k)].waddr == fwd_waddr_i) begin
                for (int b = 0; b < LANES; b++) begin
                    if (entries[PTR_W'(head + k)].mask[b]) begin
                        fwd_mask_o[b]         = 1'b1;
                        fwd_data_o[b*8 +: 8] = entries[PTR_W'(head + k)].data[b*8 +: 8];
                    end
                end
            end
        end
    end

    // issuer must honour the full level
    a_no_enq_full: assert property (@(posedge clk) disable iff (reset_i)
        enq_i |-> !full_o);

    // commit pulses only retire stores that were buffered
    a_no_commit_empty: assert property (@(posedge clk) disable iff (reset_i)
        commit_i |-> count != '0);

endmodule

// ==== hdl/data_ram.sv ====
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module data_ram (
    input  logic               clk,
    input  lsu_pkg::waddr_t    raddr_i,
    output lsu_pkg::xlen_t     rdata_o,
    input  logic               we_i,
    input  lsu_pkg::sb_entry_t wentry_i
);
    import lsu_pkg::*;

    localparam int LANES = $bits(bmask_t);

    xlen_t mem [`LSU_RAM_WORDS];

    initial begin
        for (int i = 0; i < `LSU_RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // read sees the old word on a same-edge write
    always_ff @(posedge clk) begin
        rdata_o <= mem[raddr_i];
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int b = 0; b < LANES; b++) begin
                if (wentry_i.mask[b]) begin
                    mem[wentry_i.waddr][b*8 +: 8] <= wentry_i.data[b*8 +: 8];
                end
            end
        end
    end

endmodule

// ==== hdl/load_pipe.sv ====
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module load_pipe (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              valid_i,
    input  lsu_pkg::lsu_req_t req_i,
    output lsu_pkg::waddr_t   ram_raddr_o,
    input  lsu_pkg::xlen_t    ram_rdata_i,
    output lsu_pkg::waddr_t   fwd_waddr_o,
    input  lsu_pkg::bmask_t   fwd_mask_i,
    input  lsu_pkg::xlen_t    fwd_data_i,
    output lsu_pkg::lsu_wb_t  wb_o
);
    import lsu_pkg::*;

    localparam int LANES = $bits(bmask_t);

    addr_t  addr;
    bmask_t mask;
    logic   misalign;

    logic       s1_valid;
    tag_t       s1_tag;
    mem_size_e  s1_size;
    logic       s1_uext;
    logic [1:0] s1_offset;
    logic       s1_misalign;
    bmask_t     s1_fwd_mask;
    xlen_t      s1_fwd_data;

    xlen_t merged;
    xlen_t shifted;
    xlen_t load_data;

    lsu_addr_gen u_agen (
        .req_i      (req_i),
        .addr_o     (addr),
        .mask_o     (mask),
        .misalign_o (misalign)
    );

    assign ram_raddr_o = addr[`LSU_ADDR_W-1:2];
    assign fwd_waddr_o = addr[`LSU_ADDR_W-1:2];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= valid_i;
        end
        s1_tag      <= req_i.tag;
        s1_size     <= req_i.size;
        s1_uext     <= req_i.uext;
        s1_offset   <= addr[1:0];
        s1_misalign <= misalign;
        // keep only lanes this load reads
        s1_fwd_mask <= fwd_mask_i & mask;
        s1_fwd_data <= fwd_data_i;
    end

    // buffered bytes override the ram word
    always_comb begin
        for (int b = 0; b < LANES; b++) begin
            merged[b*8 +: 8] = s1_fwd_mask[b] ? s1_fwd_data[b*8 +: 8] : ram_rdata_i[b*8 +: 8];
        end
    end

    assign shifted = merged >> {s1_offset, 3'b000};

    always_comb begin
        case (s1_size)
            SIZE_B:  load_data = {{(`LSU_XLEN-8){~s1_uext & shifted[7]}}, shifted[7:0]};
            SIZE_H:  load_data = {{(`LSU_XLEN-16){~s1_uext & shifted[15]}}, shifted[15:0]};
            default: load_data = shifted;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_o.valid <= 1'b0;
        end else begin
            wb_o.valid <= s1_valid;
        end
        wb_o.tag     <= s1_tag;
        wb_o.data    <= s1_misalign ? '0 : load_data;
        wb_o.exccode <= s1_misalign ? `LSU_EXC_LAM : `LSU_EXC_NONE;
    end

endmodule

// ==== hdl/lsu_top.sv ====
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_top (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              load_valid_i,
    input  lsu_pkg::lsu_req_t load_req_i,
    input  logic              store_valid_i,
    input  lsu_pkg::lsu_req_t store_req_i,
    input  logic              commit_i,
    output lsu_pkg::lsu_wb_t  load_wb_o,
    output lsu_pkg::lsu_wb_t  store_wb_o,
    output logic              sb_full_o
);
    import lsu_pkg::*;

    addr_t     st_addr;
    bmask_t    st_mask;
    logic      st_misalign;
    sb_entry_t st_entry;
    logic      st_enq;

    waddr_t    ld_raddr;
    xlen_t     ld_rdata;
    waddr_t    fwd_waddr;
    bmask_t    fwd_mask;
    xlen_t     fwd_data;
    logic      ram_we;
    sb_entry_t ram_entry;

    lsu_addr_gen u_st_agen (
        .req_i      (store_req_i),
        .addr_o     (st_addr),
        .mask_o     (st_mask),
        .misalign_o (st_misalign)
    );

    // store data moved into its byte lanes before buffering
    assign st_entry.waddr = st_addr[`LSU_ADDR_W-1:2];
    assign st_entry.mask  = st_mask;
    assign st_entry.data  = store_req_i.data << {st_addr[1:0], 3'b000};
    assign st_enq         = store_valid_i & ~st_misalign;

    store_buffer u_sb (
        .clk         (clk),
        .reset_i     (reset_i),
        .enq_i       (st_enq),
        .enq_entry_i (st_entry),
        .commit_i    (commit_i),
        .fwd_waddr_i (fwd_waddr),
        .fwd_mask_o  (fwd_mask),
        .fwd_data_o  (fwd_data),
        .ram_we_o    (ram_we),
        .ram_entry_o (ram_entry),
        .full_o      (sb_full_o)
    );

    data_ram u_ram (
        .clk      (clk),
        .raddr_i  (ld_raddr),
        .rdata_o  (ld_rdata),
        .we_i     (ram_we),
        .wentry_i (ram_entry)
    );

    load_pipe u_ld (
        .clk         (clk),
        .reset_i     (reset_i),
        .valid_i     (load_valid_i),
        .req_i       (load_req_i),
        .ram_raddr_o (ld_raddr),
        .ram_rdata_i (ld_rdata),
        .fwd_waddr_o (fwd_waddr),
        .fwd_mask_i  (fwd_mask),
        .fwd_data_i  (fwd_data),
        .wb_o        (load_wb_o)
    );

    always_ff @(posedge clk) begin
        if (reset_i) begin
            store_wb_o.valid <= 1'b0;
        end else begin
            store_wb_o.valid <= store_valid_i;
        end
        store_wb_o.tag     <= store_req_i.tag;
        store_wb_o.data    <= '0;
        store_wb_o.exccode <= st_misalign ? `LSU_EXC_SAM : `LSU_EXC_NONE;
    end

endmodule

// ==== bench/clk_gen.sv ====
`timescale 1ns/1ns

module clk_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic reset_o
);
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    // released after the second rising edge
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

// ==== bench/lsu_tb.sv ====
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_tb;
    import lsu_pkg::*;

    localparam int CLK_NS        = 4;
    localparam int BUDGET_CYCLES = 8 + 60 + 30 + 30 + 30 + 40 + 20;
    localparam int MEM_BYTES     = 1 << `LSU_ADDR_W;

    logic     clk;
    logic     reset_i;
    logic     load_valid_i;
    lsu_req_t load_req_i;
    logic     store_valid_i;
    lsu_req_t store_req_i;
    logic     commit_i;
    lsu_wb_t  load_wb_o;
    lsu_wb_t  store_wb_o;
    logic     sb_full_o;

    // reference byte model and stores not yet committed
    logic [7:0] model_mem [MEM_BYTES];
    int         pend_addr [$];
    mem_size_e  pend_size [$];
    xlen_t      pend_data [$];

    int   errors;
    int   checks;
    int   tests;
    tag_t next_tag;

    clk_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(2)) u_clk (
        .clk_o   (clk),
        .reset_o (reset_i)
    );

    lsu_top dut (
        .clk           (clk),
        .reset_i       (reset_i),
        .load_valid_i  (load_valid_i),
        .load_req_i    (load_req_i),
        .store_valid_i (store_valid_i),
        .store_req_i   (store_req_i),
        .commit_i      (commit_i),
        .load_wb_o     (load_wb_o),
        .store_wb_o    (store_wb_o),
        .sb_full_o     (sb_full_o)
    );

    function automatic int size_bytes(mem_size_e s);
        case (s)
            SIZE_B:  return 1;
            SIZE_H:  return 2;
            default: return 4;
        endcase
    endfunction

    function automatic logic is_misaligned(addr_t a, mem_size_e s);
        return (int'(a) % size_bytes(s)) != 0;
    endfunction

    // ram bytes with every pending store laid over them, oldest first
    function automatic xlen_t expected_load(addr_t addr, mem_size_e size, logic uext);
        xlen_t val;
        xlen_t d;
        int    n;
        int    a;
        n   = size_bytes(size);
        val = '0;
        for (int j = 0; j < n; j++) begin
            a = (int'(addr) + j) % MEM_BYTES;
            val[8*j +: 8] = model_mem[a];
            for (int k = 0; k < pend_addr.size(); k++) begin
                d = pend_data[k];
                for (int m = 0; m < size_bytes(pend_size[k]); m++) begin
                    if ((pend_addr[k] + m) % MEM_BYTES == a) begin
                        val[8*j +: 8] = d[8*m +: 8];
                    end
                end
            end
        end
        if (!uext && n < 4) begin
            for (int b = 8 * n; b < 32; b++) begin
                val[b] = val[8*n-1];
            end
        end
        return val;
    endfunction

    function automatic lsu_req_t build_req(xlen_t base, xlen_t imm, xlen_t data,
                                           mem_size_e size, logic uext, tag_t tag);
        lsu_req_t req;
        req.base = base;
        req.imm  = imm;
        req.data = data;
        req.size = size;
        req.uext = uext;
        req.tag  = tag;
        return req;
    endfunction

    // oldest pending store lands in the byte model
    function automatic void retire_model();
        int    a;
        xlen_t d;
        a = pend_addr.pop_front();
        d = pend_data.pop_front();
        for (int m = 0; m < size_bytes(pend_size[0]); m++) begin
            model_mem[(a + m) % MEM_BYTES] = d[8*m +: 8];
        end
        void'(pend_size.pop_front());
    endfunction

    task automatic check_value(input string name, input xlen_t got, input xlen_t exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error: %s expected %h got %h at %0t", name, exp, got, $time);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_at_start);
        tests++;
        $display("test %s finished with %0d errors", name, errors - errs_at_start);
    endtask

    task automatic send_store(input xlen_t base, input xlen_t imm, input xlen_t data,
                              input mem_size_e size);
        addr_t addr;
        exc_t  exp_exc;
        tag_t  tag;
        addr = addr_t'(base + imm);
        tag  = next_tag;
        next_tag++;
        exp_exc = is_misaligned(addr, size) ? `LSU_EXC_SAM : `LSU_EXC_NONE;
        @(negedge clk);
        store_valid_i = 1'b1;
        store_req_i   = build_req(base, imm, data, size, 1'b0, tag);
        if (exp_exc == `LSU_EXC_NONE) begin
            pend_addr.push_back(int'(addr));
            pend_size.push_back(size);
            pend_data.push_back(data);
        end
        @(negedge clk);
        store_valid_i = 1'b0;
        check_value("store_wb_o.valid", 32'(store_wb_o.valid), 32'd1);
        check_value("store_wb_o.tag", 32'(store_wb_o.tag), 32'(tag));
        check_value("store_wb_o.data", store_wb_o.data, 32'd0);
        check_value("store_wb_o.exccode", 32'(store_wb_o.exccode), 32'(exp_exc));
    endtask

    task automatic retire_store();
        @(negedge clk);
        commit_i = 1'b1;
        retire_model();
        @(negedge clk);
        commit_i = 1'b0;
    endtask

    // with_commit retires the oldest store in the issue cycle of the load
    task automatic check_load(input xlen_t base, input xlen_t imm, input mem_size_e size,
                              input logic uext, input logic with_commit);
        addr_t addr;
        xlen_t exp_data;
        exc_t  exp_exc;
        tag_t  tag;
        addr = addr_t'(base + imm);
        tag  = next_tag;
        next_tag++;
        if (is_misaligned(addr, size)) begin
            exp_data = '0;
            exp_exc  = `LSU_EXC_LAM;
        end else begin
            exp_data = expected_load(addr, size, uext);
            exp_exc  = `LSU_EXC_NONE;
        end
        @(negedge clk);
        load_valid_i = 1'b1;
        load_req_i   = build_req(base, imm, '0, size, uext, tag);
        commit_i     = with_commit;
        if (with_commit) begin
            retire_model();
        end
        @(negedge clk);
        load_valid_i = 1'b0;
        commit_i     = 1'b0;
        check_value("load_wb_o.valid", 32'(load_wb_o.valid), 32'd0);
        @(negedge clk);
        check_value("load_wb_o.valid", 32'(load_wb_o.valid), 32'd1);
        check_value("load_wb_o.tag", 32'(load_wb_o.tag), 32'(tag));
        check_value("load_wb_o.data", load_wb_o.data, exp_data);
        check_value("load_wb_o.exccode", 32'(load_wb_o.exccode), 32'(exp_exc));
    endtask

    task automatic roundtrip_sizes();
        int        errs_at_start;
        mem_size_e size;
        xlen_t     data;
        xlen_t     base;
        xlen_t     imm;
        errs_at_start = errors;
        for (int s = 0; s < 3; s++) begin
            for (int u = 0; u < 2; u++) begin
                size = mem_size_e'(s);
                // sign bit of every lane set so the two extensions differ
                data = $urandom | 32'h8080_8080;
                base = 32'h100 + 32'(s * 16 + u * 8);
                imm  = (size == SIZE_B) ? 32'd3 : (size == SIZE_H) ? 32'd2 : 32'd0;
                send_store(base, imm, data, size);
                retire_store();
                check_load(base, imm, size, u[0], 1'b0);
            end
        end
        report_test("roundtrip_sizes", errs_at_start);
    endtask

    task automatic forward_byte();
        int errs_at_start;
        errs_at_start = errors;
        send_store(32'h40, 32'd0, $urandom, SIZE_W);
        retire_store();
        send_store(32'h40, 32'd1, $urandom | 32'h80, SIZE_B);
        check_load(32'h40, 32'd0, SIZE_W, 1'b0, 1'b0);
        check_load(32'h40, 32'd1, SIZE_B, 1'b0, 1'b1);
        check_load(32'h40, 32'd0, SIZE_W, 1'b0, 1'b0);
        report_test("forward_byte", errs_at_start);
    endtask

    task automatic youngest_wins();
        int errs_at_start;
        errs_at_start = errors;
        send_store(32'h80, 32'd0, $urandom, SIZE_W);
        send_store(32'h80, 32'd2, $urandom, SIZE_H);
        send_store(32'h7f, 32'd3, $urandom, SIZE_B);
        check_load(32'h80, 32'd0, SIZE_W, 1'b0, 1'b0);
        check_load(32'h80, 32'd2, SIZE_H, 1'b1, 1'b0);
        repeat (3) retire_store();
        check_load(32'h80, 32'd0, SIZE_W, 1'b0, 1'b0);
        report_test("youngest_wins", errs_at_start);
    endtask

    task automatic misalign_cases();
        int errs_at_start;
        errs_at_start = errors;
        check_load(32'h20, 32'd1, SIZE_H, 1'b0, 1'b0);
        check_load(32'h20, 32'd2, SIZE_W, 1'b0, 1'b0);
        check_load(32'h21, 32'd2, SIZE_W, 1'b1, 1'b0);
        send_store(32'h30, 32'd1, $urandom, SIZE_W);
        send_store(32'h30, 32'd3, $urandom, SIZE_H);
        check_load(32'h30, 32'd0, SIZE_W, 1'b0, 1'b0);
        check_load(32'h30, 32'd4, SIZE_W, 1'b0, 1'b0);
        report_test("misalign_cases", errs_at_start);
    endtask

    task automatic fill_drain();
        int errs_at_start;
        errs_at_start = errors;
        for (int i = 0; i < `LSU_SB_DEPTH; i++) begin
            check_value("sb_full_o", 32'(sb_full_o), 32'd0);
            send_store(32'hc0, 32'(4 * i), $urandom, SIZE_W);
        end
        check_value("sb_full_o", 32'(sb_full_o), 32'd1);
        retire_store();
        check_value("sb_full_o", 32'(sb_full_o), 32'd0);
        repeat (`LSU_SB_DEPTH - 1) retire_store();
        for (int i = 0; i < `LSU_SB_DEPTH; i++) begin
            check_load(32'hc0, 32'(4 * i), SIZE_W, 1'b0, 1'b0);
        end
        report_test("fill_drain", errs_at_start);
    endtask

    // writeback of load i shows up two falling edges after its issue
    task automatic back_to_back();
        int        errs_at_start;
        lsu_req_t  reqs [4];
        xlen_t     exp_data [4];
        errs_at_start = errors;
        reqs[0] = build_req(32'hc0, 32'd0, '0, SIZE_W, 1'b0, 6'd10);
        reqs[1] = build_req(32'hc4, 32'd2, '0, SIZE_B, 1'b0, 6'd11);
        reqs[2] = build_req(32'hc8, 32'd2, '0, SIZE_H, 1'b1, 6'd12);
        reqs[3] = build_req(32'hcc, 32'd1, '0, SIZE_B, 1'b1, 6'd13);
        for (int i = 0; i < 4; i++) begin
            exp_data[i] = expected_load(addr_t'(reqs[i].base + reqs[i].imm),
                                        reqs[i].size, reqs[i].uext);
        end
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            load_valid_i = (i < 4);
            if (i < 4) begin
                load_req_i = reqs[i];
            end
            if (i >= 2) begin
                check_value("load_wb_o.valid", 32'(load_wb_o.valid), 32'd1);
                check_value("load_wb_o.tag", 32'(load_wb_o.tag), 32'(reqs[i-2].tag));
                check_value("load_wb_o.data", load_wb_o.data, exp_data[i-2]);
            end
        end
        load_valid_i = 1'b0;
        report_test("back_to_back", errs_at_start);
    endtask

    initial begin
        #(BUDGET_CYCLES * CLK_NS);
        $display("watchdog expired, tests did not finish within %0d cycles", BUDGET_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h3732));
        load_valid_i  = 1'b0;
        load_req_i    = '0;
        store_valid_i = 1'b0;
        store_req_i   = '0;
        commit_i      = 1'b0;
        errors        = 0;
        checks        = 0;
        tests         = 0;
        next_tag      = '0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            model_mem[i] = 8'h00;
        end
        @(negedge clk);
        while (reset_i) begin
            @(negedge clk);
        end
        roundtrip_sizes();
        forward_byte();
        youngest_wins();
        misalign_cases();
        fill_drain();
        back_to_back();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== lsu_top.f ====
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu_addr_gen.sv
hdl/store_buffer.sv
hdl/data_ram.sv
hdl/load_pipe.sv
hdl/lsu_top.sv
bench/clk_gen.sv
bench/lsu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module lsu_tb -f lsu_top.f

result=$(./obj_dir/Vlsu_tb)
echo "$result"

if grep -q "SIMULATION PASSED" <<< "$result"; then
    exit 0
fi
exit 1
